// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_top -Mdir obj_dir -o tb_top_sim
	./obj_dir/tb_top_sim | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== project.f ====
rtl/forwarding_unit_pkg.sv
rtl/forwarding_unit.sv
rtl/pipe_core.sv
rtl/apb_state_port.sv
rtl/fwd_top.sv
verif/fwd_assert.sv
verif/tb_top.sv

// ==== rtl/apb_state_port.sv ====
`timescale 1ns/1ps

module apb_state_port
  import forwarding_unit_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [7:0]        paddr,
  output logic [xlen-1:0]   prdata,
  output logic              pready,
  output logic              pslverr,
  output logic [reg_aw-1:0] rf_rd_idx,
  input  logic [xlen-1:0]   rf_rd_data,
  output logic [mem_aw-1:0] mem_rd_idx,
  input  logic [xlen-1:0]   mem_rd_data,
  input  logic [xlen-1:0]   csr_value
);

  logic            sel_rf, sel_mem, sel_csr;
  logic            err, err_q;
  logic [xlen-1:0] rd_data;

  // 0x00-0x1f regs, 0x20-0x2f memory, 0x30 csr.
  assign sel_rf  = paddr[7:5] == 3'b000;
  assign sel_mem = paddr[7:4] == 4'h2;
  assign sel_csr = paddr == 8'h30;
  assign err     = pwrite || !(sel_rf || sel_mem || sel_csr);

  assign rf_rd_idx  = paddr[reg_aw-1:0];
  assign mem_rd_idx = paddr[mem_aw-1:0];

  always_comb begin
    rd_data = '0;
    if (sel_rf) begin
      rd_data = rf_rd_data;
    end else if (sel_mem) begin
      rd_data = mem_rd_data;
    end else if (sel_csr) begin
      rd_data = csr_value;
    end
  end

  // error is latched in setup, reported in access.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (psel && !penable) begin
      err_q <= err;
    end
  end

  assign pready  = 1'b1;   // no wait states.
  assign pslverr = psel && penable && err_q;
  assign prdata  = (psel && penable && !err_q) ? rd_data : '0;

endmodule

// ==== rtl/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit
  import forwarding_unit_pkg::*;
(
  input  forwarding_type_t  forwarding_type_id,
  input  forwarding_type_t  forwarding_type_ex,
  input  forwarding_type_t  forwarding_type_mem,
  input  logic              reg_we_mem,
  input  logic              reg_we_wb,
  input  logic              zicsr_ex,
  input  logic [reg_aw-1:0] rd_ex,
  input  logic [reg_aw-1:0] rd_mem,
  input  logic [reg_aw-1:0] rd_wb,
  input  logic [reg_aw-1:0] rs1_id,
  input  logic [reg_aw-1:0] rs2_id,
  input  logic [reg_aw-1:0] rs1_ex,
  input  logic [reg_aw-1:0] rs2_ex,
  input  logic [reg_aw-1:0] rs2_mem,
  output forwarding_t       forward_rs1_id,
  output forwarding_t       forward_rs2_id,
  output forwarding_t       forward_rs1_ex,
  output forwarding_t       forward_rs2_ex,
  output forwarding_t       forward_rs2_mem
);

  // allowed producers per consumer, {ex, mem, wb}.
  logic [2:0] allow_rs1_id;
  logic [2:0] allow_rs2_id;
  logic [2:0] allow_ex;
  logic [2:0] allow_mem;

  forwarding_src_bundle_t ex_src;
  forwarding_src_bundle_t mem_src;
  forwarding_src_bundle_t wb_src;

  // only a csr result exists while still in EX.
  assign ex_src  = '{reg_we: zicsr_ex, rd: rd_ex, target_forwarding: ForwardFromEx};
  assign mem_src = '{reg_we: reg_we_mem, rd: rd_mem, target_forwarding: ForwardFromMem};
  assign wb_src  = '{reg_we: reg_we_wb, rd: rd_wb, target_forwarding: ForwardFromWb};

  // first hit wins, so callers go youngest to oldest.
  function automatic forwarding_dst_bundle_t try_src(input forwarding_dst_bundle_t dst,
                                                     input forwarding_src_bundle_t src,
                                                     input logic allow);
    forwarding_dst_bundle_t res;
    res = dst;
    if (allow && res.forward_rs == NoForwarding && src.reg_we &&
        res.rs != '0 && src.rd == res.rs) begin
      res.forward_rs = src.target_forwarding;
    end
    return res;
  endfunction

  function automatic forwarding_t pick(input logic [reg_aw-1:0] rs,
                                       input logic [2:0] allow,
                                       input forwarding_src_bundle_t ex_b,
                                       input forwarding_src_bundle_t mem_b,
                                       input forwarding_src_bundle_t wb_b);
    forwarding_dst_bundle_t dst;
    dst = '{rs: rs, forward_rs: NoForwarding};
    dst = try_src(dst, ex_b, allow[2]);
    dst = try_src(dst, mem_b, allow[1]);
    dst = try_src(dst, wb_b, allow[0]);
    return dst.forward_rs;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // consumer windows
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    allow_rs1_id = 3'b000;
    allow_rs2_id = 3'b000;
    unique case (forwarding_type_id)
      Type2: begin
        allow_rs1_id = 3'b111;
        allow_rs2_id = 3'b011;
      end
      Type1, Type1_3: begin
        // mem producers are caught again in EX.
        allow_rs1_id = 3'b001;
        allow_rs2_id = 3'b001;
      end
      default: ;
    endcase
  end

  always_comb begin
    allow_ex = 3'b000;
    unique case (forwarding_type_ex)
      Type1, Type1_3: allow_ex = 3'b011;
      default: ;
    endcase
  end

  always_comb begin
    allow_mem = 3'b000;
    if (forwarding_type_mem == Type1_3) begin
      allow_mem = 3'b001;   // store data only.
    end
  end

  assign forward_rs1_id  = pick(rs1_id, allow_rs1_id, ex_src, mem_src, wb_src);
  assign forward_rs2_id  = pick(rs2_id, allow_rs2_id, ex_src, mem_src, wb_src);
  assign forward_rs1_ex  = pick(rs1_ex, allow_ex, ex_src, mem_src, wb_src);
  assign forward_rs2_ex  = pick(rs2_ex, allow_ex, ex_src, mem_src, wb_src);
  assign forward_rs2_mem = pick(rs2_mem, allow_mem, ex_src, mem_src, wb_src);

endmodule

// ==== rtl/forwarding_unit_pkg.sv ====
package forwarding_unit_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned xlen   = 32;
  localparam int unsigned reg_aw = 5;
  localparam int unsigned mem_aw = 4;

  // ~~~~~~~~~~~~~~~~~~~~
  // encodings
  // ~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    OpNop,
    OpLi,
    OpAdd,
    OpXor,
    OpStore,
    OpCsrrw
  } opcode_t;

  // where the consumer needs its operands.
  typedef enum logic [1:0] {
    NoType,
    Type1,    // rs1/rs2 in EX.
    Type2,    // rs1/rs2 in ID.
    Type1_3   // rs1 in EX, rs2 in MEM.
  } forwarding_type_t;

  typedef enum logic [1:0] {
    NoForwarding,
    ForwardFromEx,
    ForwardFromMem,
    ForwardFromWb
  } forwarding_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // bundles
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    opcode_t           op;
    logic [reg_aw-1:0] rd;
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [xlen-1:0]   imm;
  } issue_t;

  typedef struct packed {
    issue_t            ins;
    logic              valid;
    forwarding_type_t  ftype;
    logic              reg_we;
    logic              zicsr;
    logic [xlen-1:0]   rs1_val;
    logic [xlen-1:0]   rs2_val;
    logic [xlen-1:0]   result;   // store address while a store is in flight.
  } stage_t;

  typedef struct packed {
    logic              reg_we;
    logic [reg_aw-1:0] rd;
    forwarding_t       target_forwarding;
  } forwarding_src_bundle_t;

  typedef struct packed {
    logic [reg_aw-1:0] rs;
    forwarding_t       forward_rs;
  } forwarding_dst_bundle_t;

endpackage

// ==== rtl/fwd_top.sv ====
`timescale 1ns/1ps

module fwd_top
  import forwarding_unit_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            issue_valid,
  input  issue_t          issue,
  output logic            issue_ready,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [7:0]      paddr,
  output logic [xlen-1:0] prdata,
  output logic            pready,
  output logic            pslverr
);

  forwarding_type_t  forwarding_type_id, forwarding_type_ex, forwarding_type_mem;
  logic              reg_we_mem, reg_we_wb, zicsr_ex;
  logic [reg_aw-1:0] rd_ex, rd_mem, rd_wb;
  logic [reg_aw-1:0] rs1_id, rs2_id, rs1_ex, rs2_ex, rs2_mem;
  forwarding_t       forward_rs1_id, forward_rs2_id;
  forwarding_t       forward_rs1_ex, forward_rs2_ex, forward_rs2_mem;

  // state read ports to the APB side.
  logic [reg_aw-1:0] rf_rd_idx;
  logic [mem_aw-1:0] mem_rd_idx;
  logic [xlen-1:0]   rf_rd_data, mem_rd_data, csr_value;

  pipe_core u_core (.*);

  forwarding_unit u_fwd (.*);

  apb_state_port u_apb (.*);

endmodule

// ==== rtl/pipe_core.sv ====
`timescale 1ns/1ps

module pipe_core
  import forwarding_unit_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              issue_valid,
  input  issue_t            issue,
  output logic              issue_ready,
  output forwarding_type_t  forwarding_type_id,
  output forwarding_type_t  forwarding_type_ex,
  output forwarding_type_t  forwarding_type_mem,
  output logic              reg_we_mem,
  output logic              reg_we_wb,
  output logic              zicsr_ex,
  output logic [reg_aw-1:0] rd_ex,
  output logic [reg_aw-1:0] rd_mem,
  output logic [reg_aw-1:0] rd_wb,
  output logic [reg_aw-1:0] rs1_id,
  output logic [reg_aw-1:0] rs2_id,
  output logic [reg_aw-1:0] rs1_ex,
  output logic [reg_aw-1:0] rs2_ex,
  output logic [reg_aw-1:0] rs2_mem,
  input  forwarding_t       forward_rs1_id,
  input  forwarding_t       forward_rs2_id,
  input  forwarding_t       forward_rs1_ex,
  input  forwarding_t       forward_rs2_ex,
  input  forwarding_t       forward_rs2_mem,
  input  logic [reg_aw-1:0] rf_rd_idx,
  output logic [xlen-1:0]   rf_rd_data,
  input  logic [mem_aw-1:0] mem_rd_idx,
  output logic [xlen-1:0]   mem_rd_data,
  output logic [xlen-1:0]   csr_value
);

  stage_t id_q, ex_q, mem_q, wb_q;
  stage_t id_to_ex, ex_to_mem, mem_to_wb;

  logic [xlen-1:0] rf [2**reg_aw];
  logic [xlen-1:0] scratch [2**mem_aw];
  logic [xlen-1:0] csr_q;

  logic            stall;
  logic [xlen-1:0] id_rs1_val, id_rs2_val, csr_old;
  logic [xlen-1:0] ex_a, ex_b, ex_result, st_data;

  function automatic stage_t decode(input issue_t ins);
    stage_t s;
    s       = '0;
    s.ins   = ins;
    s.valid = 1'b1;
    unique case (ins.op)
      OpLi: s.reg_we = 1'b1;
      OpAdd, OpXor: begin
        s.ftype  = Type1;
        s.reg_we = 1'b1;
      end
      OpStore: s.ftype = Type1_3;
      OpCsrrw: begin
        s.ftype  = Type2;
        s.reg_we = 1'b1;
        s.zicsr  = 1'b1;
      end
      default: ;
    endcase
    return s;
  endfunction

  function automatic logic [xlen-1:0] bypass(input forwarding_t sel,
                                             input logic [xlen-1:0] base,
                                             input logic [xlen-1:0] from_ex,
                                             input logic [xlen-1:0] from_mem,
                                             input logic [xlen-1:0] from_wb);
    logic [xlen-1:0] v;
    unique case (sel)
      ForwardFromEx:  v = from_ex;
      ForwardFromMem: v = from_mem;
      ForwardFromWb:  v = from_wb;
      default:        v = base;
    endcase
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // ID
  // ~~~~~~~~~~~~~~~~~~~~
  // csr consumer behind a non-csr writer in EX.
  assign stall = id_q.valid && id_q.ftype == Type2 && ex_q.valid && ex_q.reg_we &&
                 !ex_q.zicsr && id_q.ins.rs1 != '0 && id_q.ins.rs1 == ex_q.ins.rd;
  assign issue_ready = !stall;

  assign id_rs1_val = bypass(forward_rs1_id, rf[id_q.ins.rs1],
                             ex_q.result, mem_q.result, wb_q.result);
  assign id_rs2_val = bypass(forward_rs2_id, rf[id_q.ins.rs2],
                             ex_q.result, mem_q.result, wb_q.result);
  assign csr_old = (ex_q.valid && ex_q.zicsr) ? ex_q.rs1_val : csr_q;  // pending swap.

  always_comb begin
    id_to_ex         = id_q;
    id_to_ex.rs1_val = id_rs1_val;
    id_to_ex.rs2_val = id_rs2_val;
    id_to_ex.result  = id_q.zicsr ? csr_old : '0;
    if (stall) begin
      id_to_ex = '0;   // bubble.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // EX and MEM
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ex_a = bypass(forward_rs1_ex, ex_q.rs1_val, ex_q.result, mem_q.result, wb_q.result);
    ex_b = bypass(forward_rs2_ex, ex_q.rs2_val, ex_q.result, mem_q.result, wb_q.result);
    unique case (ex_q.ins.op)
      OpLi:    ex_result = ex_q.ins.imm;
      OpAdd:   ex_result = ex_a + ex_b;
      OpXor:   ex_result = ex_a ^ ex_b;
      OpStore: ex_result = ex_a + ex_q.ins.imm;
      OpCsrrw: ex_result = ex_q.result;
      default: ex_result = '0;
    endcase
    ex_to_mem         = ex_q;
    ex_to_mem.rs1_val = ex_a;
    ex_to_mem.rs2_val = ex_b;
    ex_to_mem.result  = ex_result;
  end

  always_comb begin
    st_data           = bypass(forward_rs2_mem, mem_q.rs2_val,
                               ex_q.result, mem_q.result, wb_q.result);
    mem_to_wb         = mem_q;
    mem_to_wb.rs2_val = st_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_q  <= '0;
      ex_q  <= '0;
      mem_q <= '0;
      wb_q  <= '0;
      csr_q <= '0;
      for (int i = 0; i < 2**reg_aw; i++) begin
        rf[i] <= '0;
      end
      for (int i = 0; i < 2**mem_aw; i++) begin
        scratch[i] <= '0;
      end
    end else begin
      if (!stall) begin
        id_q <= issue_valid ? decode(issue) : '0;
      end
      ex_q  <= id_to_ex;
      mem_q <= ex_to_mem;
      wb_q  <= mem_to_wb;
      if (ex_q.valid && ex_q.zicsr) begin
        csr_q <= ex_q.rs1_val;
      end
      if (mem_q.valid && mem_q.ins.op == OpStore) begin
        scratch[mem_q.result[mem_aw-1:0]] <= st_data;   // address wraps mod 16.
      end
      if (wb_q.valid && wb_q.reg_we && wb_q.ins.rd != '0) begin
        rf[wb_q.ins.rd] <= wb_q.result;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // forwarding unit taps
  // ~~~~~~~~~~~~~~~~~~~~
  assign forwarding_type_id  = id_q.ftype;
  assign forwarding_type_ex  = ex_q.ftype;
  assign forwarding_type_mem = mem_q.ftype;
  assign reg_we_mem = mem_q.valid && mem_q.reg_we;
  assign reg_we_wb  = wb_q.valid && wb_q.reg_we;
  assign zicsr_ex   = ex_q.valid && ex_q.zicsr;
  assign rd_ex   = ex_q.ins.rd;
  assign rd_mem  = mem_q.ins.rd;
  assign rd_wb   = wb_q.ins.rd;
  assign rs1_id  = id_q.ins.rs1;
  assign rs2_id  = id_q.ins.rs2;
  assign rs1_ex  = ex_q.ins.rs1;
  assign rs2_ex  = ex_q.ins.rs2;
  assign rs2_mem = mem_q.ins.rs2;

  assign rf_rd_data  = rf[rf_rd_idx];
  assign mem_rd_data = scratch[mem_rd_idx];
  assign csr_value   = csr_q;

endmodule

// ==== verif/fwd_assert.sv ====
`timescale 1ns/1ps

module fwd_assert
  import forwarding_unit_pkg::*;
(
  input logic              clk,
  input logic              rst_n,
  input logic              issue_ready,
  input logic              zicsr_ex,
  input logic [reg_aw-1:0] rs1_id,
  input logic [reg_aw-1:0] rs2_id,
  input logic [reg_aw-1:0] rs1_ex,
  input logic [reg_aw-1:0] rs2_ex,
  input logic [reg_aw-1:0] rs2_mem,
  input forwarding_t       forward_rs1_id,
  input forwarding_t       forward_rs2_id,
  input forwarding_t       forward_rs1_ex,
  input forwarding_t       forward_rs2_ex,
  input forwarding_t       forward_rs2_mem
);

  // x0 is hardwired, never a bypass target.
  a_no_x0: assert property (@(posedge clk) disable iff (!rst_n)
    (forward_rs1_id == NoForwarding || rs1_id != '0) &&
    (forward_rs2_id == NoForwarding || rs2_id != '0) &&
    (forward_rs1_ex == NoForwarding || rs1_ex != '0) &&
    (forward_rs2_ex == NoForwarding || rs2_ex != '0) &&
    (forward_rs2_mem == NoForwarding || rs2_mem != '0))
    else $error("forwarding select points at x0");

  a_ex_only_csr: assert property (@(posedge clk) disable iff (!rst_n)
    (forward_rs1_id == ForwardFromEx || forward_rs2_id == ForwardFromEx ||
     forward_rs1_ex == ForwardFromEx || forward_rs2_ex == ForwardFromEx ||
     forward_rs2_mem == ForwardFromEx) |-> zicsr_ex)
    else $error("bypass from EX without a CSR instruction in EX");

  a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    !issue_ready |=> issue_ready)
    else $error("issue_ready low for more than one cycle");

endmodule

bind pipe_core fwd_assert u_fwd_assert (
  .clk             (clk),
  .rst_n           (rst_n),
  .issue_ready     (issue_ready),
  .zicsr_ex        (zicsr_ex),
  .rs1_id          (rs1_id),
  .rs2_id          (rs2_id),
  .rs1_ex          (rs1_ex),
  .rs2_ex          (rs2_ex),
  .rs2_mem         (rs2_mem),
  .forward_rs1_id  (forward_rs1_id),
  .forward_rs2_id  (forward_rs2_id),
  .forward_rs1_ex  (forward_rs1_ex),
  .forward_rs2_ex  (forward_rs2_ex),
  .forward_rs2_mem (forward_rs2_mem)
);

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top
  import forwarding_unit_pkg::*;
();

  localparam int n_instr     = 200 + 100 + 80 + 40;
  localparam int cycle_limit = n_instr * 3 + 200;

  logic            clk, rst_n, issue_valid, issue_ready;
  issue_t          issue;
  logic            psel, penable, pwrite, pready, pslverr;
  logic [7:0]      paddr;
  logic [xlen-1:0] prdata;

  // sequential reference state.
  logic [xlen-1:0] m_rf [32];
  logic [xlen-1:0] m_mem [16];
  logic [xlen-1:0] m_csr;

  integer            seed = 32'hf7c8;
  int                cycles = 0;
  int                errors = 0;
  int                test_errors = 0;
  int                tests_failed = 0;
  string             cur_test = "";
  logic [reg_aw-1:0] prev_rd = '0;

  issue_t sh_id, sh_ex;   // ID and EX as the stall rule sees them.
  logic   sh_id_v, sh_ex_v, exp_stall;

  fwd_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stall prediction
  // ~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      sh_id_v = 1'b0;
      sh_ex_v = 1'b0;
    end else begin
      exp_stall = sh_id_v && sh_id.op == OpCsrrw && sh_ex_v && sh_id.rs1 != '0 &&
                  sh_id.rs1 == sh_ex.rd && sh_ex.op inside {OpLi, OpAdd, OpXor};
      assert (issue_ready == !exp_stall) else begin
        $display("Error %s: issue_ready expected %0b actual %0b",
                 cur_test, !exp_stall, issue_ready);
        errors++;
      end
      if (exp_stall) begin
        sh_ex_v = 1'b0;   // bubble, ID holds.
      end else begin
        sh_ex_v = sh_id_v;
        sh_ex   = sh_id;
        sh_id_v = issue_valid;
        sh_id   = issue;
      end
    end
  end

  task automatic model_exec(input issue_t i);
    logic [xlen-1:0] a, b, res, addr;
    a    = m_rf[i.rs1];
    b    = m_rf[i.rs2];
    addr = a + i.imm;
    res  = (i.op == OpLi) ? i.imm : (i.op == OpAdd) ? a + b : (i.op == OpXor) ? a ^ b : m_csr;
    if (i.op == OpCsrrw) m_csr = a;   // swap, old value goes to rd.
    if (i.op == OpStore) m_mem[addr[3:0]] = b;
    if (i.op inside {OpLi, OpAdd, OpXor, OpCsrrw} && i.rd != '0) m_rf[i.rd] = res;
  endtask

  function automatic issue_t gen(input int mode);
    issue_t          i;
    logic [31:0]     r;
    logic [4:0]      mask;
    opcode_t         ops [4];
    r    = $random(seed);
    mask = (mode == 5) ? 5'd3 : 5'd7;
    case (mode)
      2:       ops = '{OpLi, OpAdd, OpXor, OpAdd};
      3:       ops = '{OpLi, OpAdd, OpStore, OpStore};
      4:       ops = '{OpLi, OpAdd, OpCsrrw, OpCsrrw};
      default: ops = '{OpLi, OpXor, OpCsrrw, OpNop};
    endcase
    i.op  = ops[r[1:0]];
    i.rd  = r[6:2] & mask;
    i.rs1 = r[11:7] & mask;
    i.rs2 = r[16:12] & mask;
    if (r[17]) i.rs1 = prev_rd;   // back-to-back dependency.
    i.imm   = $random(seed);
    prev_rd = i.rd;
    return i;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // drivers
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic send(input issue_t i);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue       <= i;
    @(negedge clk);
    while (!issue_ready) @(negedge clk);
    model_exec(i);   // accepted on the coming edge.
  endtask

  task automatic run_program(input int mode, input int count);
    logic [31:0] r;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        @(posedge clk);
        issue_valid <= 1'b0;
      end
      send(gen(mode));
    end
    @(posedge clk);
    issue_valid <= 1'b0;
    repeat (8) @(posedge clk);   // drain.
  endtask

  task automatic apb_xfer(input logic [7:0] addr, input logic wr,
                          output logic [xlen-1:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    assert (pready) else begin
      $display("%s: APB access at %02h saw pready low", cur_test, addr);
      errors++;
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic check_read(input logic [7:0] addr, input logic [xlen-1:0] exp);
    logic [xlen-1:0] d;
    logic            e;
    apb_xfer(addr, 1'b0, d, e);
    assert (!e) else begin
      $display("%s: APB read at %02h ended with pslverr", cur_test, addr);
      errors++;
    end
    assert (d == exp) else begin
      $display("Error %s: addr %02h expected %08h actual %08h", cur_test, addr, exp, d);
      errors++;
    end
  endtask

  task automatic check_error(input logic [7:0] addr, input logic wr);
    logic [xlen-1:0] d;
    logic            e;
    apb_xfer(addr, wr, d, e);
    assert (e) else begin
      $display("%s: APB %s at %02h completed without pslverr", cur_test,
               wr ? "write" : "read", addr);
      errors++;
    end
    assert (d == '0) else begin
      $display("Error %s: prdata at %02h expected %08h actual %08h", cur_test, addr, 0, d);
      errors++;
    end
  endtask

  task automatic check_regs();
    for (int k = 0; k < 32; k++) check_read(8'(k), m_rf[k]);
  endtask

  task automatic check_mem();
    for (int k = 0; k < 16; k++) check_read(8'h20 + 8'(k), m_mem[k]);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_errors);
      tests_failed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    m_csr       = '0;
    for (int k = 0; k < 32; k++) m_rf[k] = '0;
    for (int k = 0; k < 16; k++) m_mem[k] = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset_state");
    check_regs();
    check_mem();
    check_read(8'h30, m_csr);
    end_test();

    start_test("add_xor_chains");
    run_program(2, 200);
    check_regs();
    end_test();

    start_test("stores");
    run_program(3, 100);
    check_mem();
    end_test();

    start_test("csrrw");
    run_program(4, 80);
    check_regs();
    check_read(8'h30, m_csr);
    end_test();

    start_test("x0");
    run_program(5, 40);   // x0..x3 only, so x0 is hit often.
    check_regs();
    end_test();

    start_test("apb_errors");
    check_error(8'h04, 1'b1);
    check_error(8'h31, 1'b0);
    end_test();

    $display("tests: 6, failed: %0d, errors: %0d", tests_failed, errors);
    if (tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
